/* src/dma_pkg.sv */
// shared constants for the DMA controller; register slots assume at most 7 channels
// BCR low half is a plain word count, only sync modes 0 and 1 are supported
package dma_pkg;

   typedef logic [31:0] word_t;
   typedef logic [2:0]  chan_idx_t;
   typedef logic [2:0]  prio_t;      // lower value wins

   // word offsets inside a channel's 4-word slot
   localparam logic [1:0] REG_MADR = 2'd0;
   localparam logic [1:0] REG_BCR  = 2'd1;
   localparam logic [1:0] REG_CHCR = 2'd2;

   // shared registers above the channel slots
   localparam logic [4:0] REG_DPCR = 5'd28;
   localparam logic [4:0] REG_DICR = 5'd29;

   // CHCR fields
   localparam int CHCR_TO_PERIPH_BIT = 0;   // set: memory to peripheral
   localparam int CHCR_ADDR_DEC_BIT  = 1;   // set: MADR steps down
   localparam int CHCR_MODE_LSB      = 9;
   localparam int CHCR_START_BIT     = 24;
   localparam int CHCR_TRIGGER_BIT   = 28;  // mode 0 only

   localparam logic [1:0] SYNC_MODE0 = 2'b00;  // ordering table clear
   localparam logic [1:0] SYNC_MODE1 = 2'b01;  // block transfer

   localparam word_t END_CODE  = 32'h00FF_FFFF;
   localparam word_t WORD_STEP = 32'd4;

   // DICR fields
   localparam int DICR_EN_LSB        = 16;
   localparam int DICR_MASTER_EN_BIT = 23;
   localparam int DICR_FLAG_LSB      = 24;
   localparam int DICR_SUMMARY_BIT   = 31;

endpackage

/* src/dma_if.sv */
// per-channel links inside the DMA controller
// strobes are one-cycle pulses; memory handshake holds ren/wen until ack
`timescale 1ns/1ps

interface chan_regs_if;

   dma_pkg::word_t madr;
   dma_pkg::word_t bcr;
   dma_pkg::word_t chcr;
   logic           madr_step;   // move MADR one word
   logic           bcr_decr;    // count down BCR low half
   logic           chan_end;    // clear start bit

   modport bank (
      output madr, bcr, chcr,
      input  madr_step, bcr_decr, chan_end
   );

   modport channel (
      input  madr, bcr, chcr,
      output madr_step, bcr_decr, chan_end
   );

endinterface

interface mem_port_if;

   logic           ren;
   logic           wen;
   dma_pkg::word_t addr;
   dma_pkg::word_t wdata;
   dma_pkg::word_t rdata;
   logic           ack;

   modport channel (
      output ren, wen, addr, wdata,
      input  rdata, ack
   );

   modport controller (
      input  ren, wen, addr, wdata,
      output rdata, ack
   );

endinterface

/* src/dma_reg_bank.sv */
// MADR/BCR/CHCR per channel plus DPCR; a register write beats a channel strobe
// in the same cycle. reads are combinational, DICR is read from dma_interrupts
`timescale 1ns/1ps

module dma_reg_bank #(
   parameter int NUM_CHANNELS = 7
) (
   input  logic           sys_clk,
   input  logic           rst,
   input  logic           reg_wen_i,
   input  logic [4:0]     reg_addr_i,
   input  dma_pkg::word_t reg_wdata_i,
   input  dma_pkg::word_t dicr_i,
   output dma_pkg::word_t reg_rdata_o,
   output dma_pkg::word_t dpcr_o,
   output logic           dicr_wen_o,
   chan_regs_if.bank      regs [NUM_CHANNELS-1:0]
);

   dma_pkg::word_t     madr_q [NUM_CHANNELS];
   dma_pkg::word_t     bcr_q  [NUM_CHANNELS];
   dma_pkg::word_t     chcr_q [NUM_CHANNELS];
   dma_pkg::word_t     dpcr_q;
   dma_pkg::chan_idx_t slot;

   assign slot       = reg_addr_i[4:2];   // channel n at n*4
   assign dpcr_o     = dpcr_q;
   assign dicr_wen_o = reg_wen_i && reg_addr_i == dma_pkg::REG_DICR;

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         dpcr_q <= '0;
      end else if (reg_wen_i && reg_addr_i == dma_pkg::REG_DPCR) begin
         dpcr_q <= reg_wdata_i;
      end
   end

   for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_slot
      logic           wr_slot;
      dma_pkg::word_t madr_next;

      assign wr_slot   = reg_wen_i && slot == dma_pkg::chan_idx_t'(i);
      assign madr_next = chcr_q[i][dma_pkg::CHCR_ADDR_DEC_BIT] ?
                         madr_q[i] - dma_pkg::WORD_STEP : madr_q[i] + dma_pkg::WORD_STEP;

      always_ff @(posedge sys_clk or posedge rst) begin
         if (rst) begin
            madr_q[i] <= '0;
            bcr_q[i]  <= '0;
            chcr_q[i] <= '0;
         end else begin
            if (wr_slot && reg_addr_i[1:0] == dma_pkg::REG_MADR) begin
               madr_q[i] <= reg_wdata_i;
            end else if (regs[i].madr_step) begin
               madr_q[i] <= madr_next;
            end
            if (wr_slot && reg_addr_i[1:0] == dma_pkg::REG_BCR) begin
               bcr_q[i] <= reg_wdata_i;
            end else if (regs[i].bcr_decr) begin
               bcr_q[i][15:0] <= bcr_q[i][15:0] - 16'd1;   // upper half untouched
            end
            if (wr_slot && reg_addr_i[1:0] == dma_pkg::REG_CHCR) begin
               chcr_q[i] <= reg_wdata_i;
            end else if (regs[i].chan_end) begin
               chcr_q[i][dma_pkg::CHCR_START_BIT] <= 1'b0;
            end
         end
      end

      assign regs[i].madr = madr_q[i];
      assign regs[i].bcr  = bcr_q[i];
      assign regs[i].chcr = chcr_q[i];

      // every address step belongs to a counted word
      a_step_counted: assert property (@(posedge sys_clk) disable iff (rst)
         regs[i].madr_step |-> regs[i].bcr_decr);
   end

   always_comb begin
      reg_rdata_o = '0;
      if (reg_addr_i == dma_pkg::REG_DPCR) begin
         reg_rdata_o = dpcr_q;
      end else if (reg_addr_i == dma_pkg::REG_DICR) begin
         reg_rdata_o = dicr_i;
      end else if (int'(slot) < NUM_CHANNELS) begin
         case (reg_addr_i[1:0])
            dma_pkg::REG_MADR: reg_rdata_o = madr_q[slot];
            dma_pkg::REG_BCR:  reg_rdata_o = bcr_q[slot];
            dma_pkg::REG_CHCR: reg_rdata_o = chcr_q[slot];
            default:           reg_rdata_o = '0;   // unused 4th word
         endcase
      end
   end

endmodule

/* src/dma_interrupts.sv */
// DICR with per-channel flags, write one to clear; no force bit
// a flag only sets when master enable and its own enable are both on
`timescale 1ns/1ps

module dma_interrupts #(
   parameter int NUM_CHANNELS = 7
) (
   input  logic                    sys_clk,
   input  logic                    rst,
   input  logic [NUM_CHANNELS-1:0] irq_pulse_i,
   input  logic                    wen_i,
   input  dma_pkg::word_t          wdata_i,
   output dma_pkg::word_t          dicr_o,
   output logic                    irq_o
);

   logic [NUM_CHANNELS-1:0] en_q;
   logic [NUM_CHANNELS-1:0] flag_q;
   logic                    master_q;
   logic                    summary;

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         en_q     <= '0;
         flag_q   <= '0;
         master_q <= 1'b0;
      end else if (wen_i) begin
         en_q     <= wdata_i[dma_pkg::DICR_EN_LSB +: NUM_CHANNELS];
         master_q <= wdata_i[dma_pkg::DICR_MASTER_EN_BIT];
         flag_q   <= flag_q & ~wdata_i[dma_pkg::DICR_FLAG_LSB +: NUM_CHANNELS];
      end else begin
         flag_q <= flag_q | (irq_pulse_i & en_q & {NUM_CHANNELS{master_q}});
      end
   end

   assign summary = |(flag_q & en_q);
   assign irq_o   = summary;

   always_comb begin
      dicr_o = '0;
      dicr_o[dma_pkg::DICR_EN_LSB +: NUM_CHANNELS]   = en_q;
      dicr_o[dma_pkg::DICR_MASTER_EN_BIT]            = master_q;
      dicr_o[dma_pkg::DICR_FLAG_LSB +: NUM_CHANNELS] = flag_q;
      dicr_o[dma_pkg::DICR_SUMMARY_BIT]              = summary;
   end

endmodule

/* src/dma_channel.sv */
// one word per start; mode 0 expects CHCR decrement bit set so MADR walks down
// a start with count 0 only raises irq and clears the start bit
`timescale 1ns/1ps

module dma_channel (
   input  logic           sys_clk,
   input  logic           rst,
   input  logic           start_i,
   output logic           done_o,
   output logic           req_o,
   output logic           irq_o,
   chan_regs_if.channel   regs,
   mem_port_if.channel    mem,
   input  logic           chan_rdy_i,
   input  logic           chan_full_i,
   input  dma_pkg::word_t chan_rdata_i,
   output logic           chan_ren_o,
   output logic           chan_wen_o,
   output dma_pkg::word_t chan_wdata_o
);

   localparam logic [5:0] ST_IDLE    = 6'b000001;
   localparam logic [5:0] ST_START   = 6'b000010;
   localparam logic [5:0] ST_PREAD   = 6'b000100;   // wait for peripheral data
   localparam logic [5:0] ST_MEM     = 6'b001000;   // bus access until ack
   localparam logic [5:0] ST_RELEASE = 6'b010000;   // wait for ack to fall
   localparam logic [5:0] ST_PWRITE  = 6'b100000;   // push word to peripheral

   logic [5:0]     state_q, state_d;
   logic           ren_q, ren_d;
   logic           wen_q, wen_d;
   dma_pkg::word_t addr_q, addr_d;
   dma_pkg::word_t data_q, data_d;                  // also the peripheral latch
   logic [1:0]     mode;
   logic           to_periph;
   logic [15:0]    count;

   assign mode      = regs.chcr[dma_pkg::CHCR_MODE_LSB +: 2];
   assign to_periph = regs.chcr[dma_pkg::CHCR_TO_PERIPH_BIT];
   assign count     = regs.bcr[15:0];
   assign req_o     = regs.chcr[dma_pkg::CHCR_START_BIT] &&
                      (mode == dma_pkg::SYNC_MODE1 ||
                       (mode == dma_pkg::SYNC_MODE0 && regs.chcr[dma_pkg::CHCR_TRIGGER_BIT]));

   assign mem.ren      = ren_q;
   assign mem.wen      = wen_q;
   assign mem.addr     = addr_q;
   assign mem.wdata    = data_q;
   assign chan_wdata_o = (state_q == ST_PWRITE) ? data_q : '0;   // zero so top can OR

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         state_q <= ST_IDLE;
         ren_q   <= 1'b0;
         wen_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         ren_q   <= ren_d;
         wen_q   <= wen_d;
      end
   end

   always_ff @(posedge sys_clk) begin
      addr_q <= addr_d;
      data_q <= data_d;
   end

   always_comb begin
      state_d = state_q;
      ren_d   = ren_q;
      wen_d   = wen_q;
      addr_d  = addr_q;
      data_d  = data_q;
      done_o  = 1'b0;
      irq_o   = 1'b0;
      chan_ren_o     = 1'b0;
      chan_wen_o     = 1'b0;
      regs.madr_step = 1'b0;
      regs.bcr_decr  = 1'b0;
      regs.chan_end  = 1'b0;
      case (state_q)
         ST_IDLE: if (start_i) state_d = ST_START;
         ST_START: begin
            addr_d = regs.madr;
            if (count == 16'd0) begin
               irq_o         = 1'b1;   // transfer finished on an earlier grant
               regs.chan_end = 1'b1;
               done_o        = 1'b1;
               state_d       = ST_IDLE;
            end else if (mode == dma_pkg::SYNC_MODE0) begin
               data_d  = (count == 16'd1) ? dma_pkg::END_CODE
                                          : regs.madr - dma_pkg::WORD_STEP;
               wen_d   = 1'b1;
               state_d = ST_MEM;
            end else if (to_periph) begin
               ren_d   = 1'b1;
               state_d = ST_MEM;
            end else begin
               state_d = ST_PREAD;
            end
         end
         ST_PREAD: if (chan_rdy_i) begin
            chan_ren_o = 1'b1;
            data_d     = chan_rdata_i;
            wen_d      = 1'b1;
            state_d    = ST_MEM;
         end
         ST_MEM: if (mem.ack) begin
            if (ren_q) data_d = mem.rdata;
            ren_d   = 1'b0;
            wen_d   = 1'b0;
            state_d = ST_RELEASE;
         end
         ST_RELEASE: if (!mem.ack) begin
            if (mode == dma_pkg::SYNC_MODE1 && to_periph) begin
               state_d = ST_PWRITE;
            end else begin
               regs.madr_step = 1'b1;
               regs.bcr_decr  = 1'b1;
               done_o         = 1'b1;
               state_d        = ST_IDLE;
            end
         end
         ST_PWRITE: if (!chan_full_i) begin
            chan_wen_o     = 1'b1;
            regs.madr_step = 1'b1;
            regs.bcr_decr  = 1'b1;
            done_o         = 1'b1;
            state_d        = ST_IDLE;
         end
         default: state_d = ST_IDLE;
      endcase
   end

   a_one_dir: assert property (@(posedge sys_clk) disable iff (rst) !(mem.ren && mem.wen));

   // the controller only grants a channel that has returned to idle
   a_start_idle: assert property (@(posedge sys_clk) disable iff (rst)
      start_i |-> state_q == ST_IDLE);

endmodule

/* src/dma_controller.sv */
// picks the DPCR winner on each bus grant and routes its memory port out
// a grant with no enabled requester ends at once with dma_done_o
`timescale 1ns/1ps

module dma_controller #(
   parameter int NUM_CHANNELS = 7
) (
   input  logic                    sys_clk,
   input  logic                    rst,
   input  dma_pkg::word_t          dpcr_i,
   input  logic [NUM_CHANNELS-1:0] req_i,
   input  logic [NUM_CHANNELS-1:0] done_i,
   output logic [NUM_CHANNELS-1:0] start_o,
   input  logic                    dma_en_i,
   output logic                    dma_req_o,
   output logic                    dma_done_o,
   mem_port_if.controller          mem [NUM_CHANNELS-1:0],
   output logic                    mem_ren_o,
   output logic                    mem_wen_o,
   output dma_pkg::word_t          mem_addr_o,
   output dma_pkg::word_t          mem_wdata_o,
   input  dma_pkg::word_t          mem_rdata_i,
   input  logic                    mem_ack_i
);

   localparam logic [2:0] ST_IDLE   = 3'b001;
   localparam logic [2:0] ST_ASSIGN = 3'b010;
   localparam logic [2:0] ST_WAIT   = 3'b100;

   logic [2:0]              state_q, state_d;
   dma_pkg::chan_idx_t      active_q;
   dma_pkg::chan_idx_t      win_idx;
   logic                    win_vld;
   logic [NUM_CHANNELS-1:0] win_oh;
   logic [NUM_CHANNELS-1:0] ren_v, wen_v;
   dma_pkg::word_t          addr_v [NUM_CHANNELS];
   dma_pkg::word_t          wdata_v [NUM_CHANNELS];

   // lowest priority value among enabled requesters, ties to lower channel
   always_comb begin
      dma_pkg::prio_t best;
      best    = '0;
      win_vld = 1'b0;
      win_idx = '0;
      for (int i = 0; i < NUM_CHANNELS; i++) begin
         if (req_i[i] && dpcr_i[4*i+3] && (!win_vld || dpcr_i[4*i +: 3] < best)) begin
            best    = dpcr_i[4*i +: 3];
            win_idx = dma_pkg::chan_idx_t'(i);
            win_vld = 1'b1;
         end
      end
      win_oh = '0;
      if (win_vld) win_oh[win_idx] = 1'b1;
   end

   assign dma_req_o = win_vld;

   for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_port
      assign ren_v[i]     = mem[i].ren;
      assign wen_v[i]     = mem[i].wen;
      assign addr_v[i]    = mem[i].addr;
      assign wdata_v[i]   = mem[i].wdata;
      assign mem[i].rdata = mem_rdata_i;
      assign mem[i].ack   = mem_ack_i && active_q == dma_pkg::chan_idx_t'(i);
   end

   // bus mux steered by the latched channel
   assign mem_ren_o   = ren_v[active_q];
   assign mem_wen_o   = wen_v[active_q];
   assign mem_addr_o  = addr_v[active_q];
   assign mem_wdata_o = wdata_v[active_q];

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         state_q  <= ST_IDLE;
         active_q <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == ST_ASSIGN) active_q <= win_idx;
      end
   end

   always_comb begin
      state_d    = state_q;
      start_o    = '0;
      dma_done_o = 1'b0;
      case (state_q)
         ST_IDLE: if (dma_en_i) state_d = ST_ASSIGN;
         ST_ASSIGN: begin
            start_o = win_oh;
            if (win_vld) begin
               state_d = ST_WAIT;
            end else begin
               dma_done_o = 1'b1;   // nothing to do, hand bus back
               state_d    = ST_IDLE;
            end
         end
         ST_WAIT: if (done_i[active_q]) begin
            dma_done_o = 1'b1;
            state_d    = ST_IDLE;
         end
         default: state_d = ST_IDLE;
      endcase
   end

   a_start_onehot: assert property (@(posedge sys_clk) disable iff (rst) $onehot0(start_o));

endmodule

/* src/dma_top.sv */
// DMA controller top with NUM_CHANNELS (1 to 7) channels on one memory bus
// chan_rdata_i packs channel n at bits [32n+31:32n]
`timescale 1ns/1ps

module dma_top #(
   parameter int NUM_CHANNELS = 7
) (
   input  logic                       sys_clk,
   input  logic                       rst,
   input  logic                       reg_wen_i,
   input  logic [4:0]                 reg_addr_i,
   input  dma_pkg::word_t             reg_wdata_i,
   output dma_pkg::word_t             reg_rdata_o,
   input  logic                       dma_en_i,
   output logic                       dma_req_o,
   output logic                       dma_done_o,
   output logic                       mem_ren_o,
   output logic                       mem_wen_o,
   output dma_pkg::word_t             mem_addr_o,
   output dma_pkg::word_t             mem_wdata_o,
   input  dma_pkg::word_t             mem_rdata_i,
   input  logic                       mem_ack_i,
   input  logic [NUM_CHANNELS-1:0]    chan_rdy_i,
   input  logic [NUM_CHANNELS-1:0]    chan_full_i,
   input  logic [32*NUM_CHANNELS-1:0] chan_rdata_i,
   output logic [NUM_CHANNELS-1:0]    chan_ren_o,
   output logic [NUM_CHANNELS-1:0]    chan_wen_o,
   output dma_pkg::word_t             chan_wdata_o,
   output logic                       irq_o
);

   dma_pkg::word_t          dpcr, dicr;
   logic                    dicr_wen;
   logic [NUM_CHANNELS-1:0] ch_req, ch_done, ch_start, ch_irq;
   dma_pkg::word_t          ch_wdata [NUM_CHANNELS];

   chan_regs_if regs_if [NUM_CHANNELS-1:0] ();
   mem_port_if  mem_if  [NUM_CHANNELS-1:0] ();

   dma_reg_bank #(.NUM_CHANNELS(NUM_CHANNELS)) u_reg_bank (
      .sys_clk, .rst, .reg_wen_i, .reg_addr_i, .reg_wdata_i,
      .dicr_i     (dicr),
      .reg_rdata_o,
      .dpcr_o     (dpcr),
      .dicr_wen_o (dicr_wen),
      .regs       (regs_if)
   );

   dma_interrupts #(.NUM_CHANNELS(NUM_CHANNELS)) u_interrupts (
      .sys_clk, .rst,
      .irq_pulse_i (ch_irq),
      .wen_i       (dicr_wen),
      .wdata_i     (reg_wdata_i),
      .dicr_o      (dicr),
      .irq_o
   );

   dma_controller #(.NUM_CHANNELS(NUM_CHANNELS)) u_controller (
      .sys_clk, .rst,
      .dpcr_i  (dpcr),
      .req_i   (ch_req),
      .done_i  (ch_done),
      .start_o (ch_start),
      .dma_en_i, .dma_req_o, .dma_done_o,
      .mem     (mem_if),
      .mem_ren_o, .mem_wen_o, .mem_addr_o, .mem_wdata_o, .mem_rdata_i, .mem_ack_i
   );

   for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
      dma_channel u_channel (
         .sys_clk, .rst,
         .start_i      (ch_start[i]),
         .done_o       (ch_done[i]),
         .req_o        (ch_req[i]),
         .irq_o        (ch_irq[i]),
         .regs         (regs_if[i]),
         .mem          (mem_if[i]),
         .chan_rdy_i   (chan_rdy_i[i]),
         .chan_full_i  (chan_full_i[i]),
         .chan_rdata_i (chan_rdata_i[32*i +: 32]),
         .chan_ren_o   (chan_ren_o[i]),
         .chan_wen_o   (chan_wen_o[i]),
         .chan_wdata_o (ch_wdata[i])
      );
   end

   // idle channels drive zero, so one OR gives the shared data bus
   always_comb begin
      chan_wdata_o = '0;
      for (int i = 0; i < NUM_CHANNELS; i++) chan_wdata_o |= ch_wdata[i];
   end

endmodule

/* tests/tb_dma.sv */
// testbench for dma_top with 7 channels; registers are only written while the controller is idle
// the memory model decodes 4 KB of word addresses, all test buffers stay below that
`timescale 1ns/1ps

module tb_dma;

   localparam int NCH             = 7;
   localparam int CLK_NS          = 20;
   localparam int MAX_GRANTS      = 43;    // 9 + 7 + 7 + 12 + 8 over the tests
   localparam int READBACKS       = 18;    // full register sweeps of 30 reads
   localparam int WATCHDOG_CYCLES = MAX_GRANTS * 40 + READBACKS * 60 + 400;

   logic              sys_clk, rst;
   logic              reg_wen_i;
   logic [4:0]        reg_addr_i;
   logic [31:0]       reg_wdata_i, reg_rdata_o;
   logic              dma_en_i, dma_req_o, dma_done_o;
   logic              mem_ren_o, mem_wen_o, mem_ack_i;
   logic [31:0]       mem_addr_o, mem_wdata_o, mem_rdata_i;
   logic [NCH-1:0]    chan_rdy_i, chan_full_i, chan_ren_o, chan_wen_o;
   logic [32*NCH-1:0] chan_rdata_i;
   logic [31:0]       chan_wdata_o;
   logic              irq_o;

   logic [31:0]  lcg_state = 32'd56;
   logic [31:0]  mem_model [1024];
   int unsigned  ack_wait;
   logic [31:0]  periph_r;
   logic [31:0]  pdata_q [$];                  // words handed out on chan_ren_o
   logic [31:0]  wdata_q [$];                  // words seen on chan_wen_o
   logic         seen_access;
   logic [31:0]  first_addr;

   // register and interrupt model
   logic [31:0]    m_madr [NCH];
   logic [31:0]    m_bcr [NCH];
   logic [31:0]    m_chcr [NCH];
   logic [31:0]    m_dpcr;
   logic [NCH-1:0] m_en, m_flag;
   logic           m_master;

   string cur_test;
   int    checks, errors, test_errors, tests_run, tests_failed;

   dma_top #(.NUM_CHANNELS(NCH)) dut (.*);

   initial begin
      sys_clk = 1'b0;
      forever #(CLK_NS / 2) sys_clk = ~sys_clk;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_NS);
      $display("watchdog expired in %s, a grant or register access never finished", cur_test);
      $display("=== FAIL ===");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int rand_below(input int n);
      return int'(next_rand() >> 8) % n;     // upper bits since low LCG bits are weak
   endfunction

   // memory slave acks after 0 to 3 cycles and drops ack once the request drops
   always @(posedge sys_clk) begin
      if ((mem_ren_o || mem_wen_o) && !mem_ack_i) begin
         if (ack_wait == 0) begin
            mem_ack_i <= 1'b1;
            if (mem_wen_o) mem_model[mem_addr_o[11:2]] = mem_wdata_o;
            else mem_rdata_i <= mem_model[mem_addr_o[11:2]];
         end else begin
            ack_wait <= ack_wait - 1;
         end
      end else if (!(mem_ren_o || mem_wen_o) && mem_ack_i) begin
         mem_ack_i <= 1'b0;
         ack_wait  <= rand_below(4);
      end
   end

   // peripherals are ready half the time and full a quarter of the time
   always @(posedge sys_clk) begin
      periph_r = next_rand();
      chan_rdy_i  <= periph_r[30:24];
      chan_full_i <= periph_r[22:16] & periph_r[14:8];
      for (int i = 0; i < NCH; i++) chan_rdata_i[32*i +: 32] <= next_rand();
   end

   always @(negedge sys_clk) begin
      for (int i = 0; i < NCH; i++) begin
         if (chan_ren_o[i]) pdata_q.push_back(chan_rdata_i[32*i +: 32]);
      end
      if (|chan_wen_o) wdata_q.push_back(chan_wdata_o);
      if ((mem_ren_o || mem_wen_o) && !seen_access) begin
         seen_access = 1'b1;
         first_addr  = mem_addr_o;
      end
   end

   task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         test_errors++;
         $display("Fail %s %s: expected %h actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic report_failure(input string what);
      checks++;
      errors++;
      test_errors++;
      $display("%s: %s", cur_test, what);
   endtask

   task automatic begin_test(input string name);
      cur_test    = name;
      test_errors = 0;
      tests_run++;
   endtask

   task automatic end_test();
      if (test_errors == 0) begin
         $display("%s: passed", cur_test);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", cur_test, test_errors);
      end
   endtask

   function automatic logic [31:0] model_read(input logic [4:0] addr);
      logic [31:0] v;
      int          slot;
      v    = '0;
      slot = int'(addr[4:2]);
      if (addr == 5'd28) begin
         v = m_dpcr;
      end else if (addr == 5'd29) begin
         v[16 +: NCH] = m_en;
         v[23]        = m_master;
         v[24 +: NCH] = m_flag;
         v[31]        = |(m_flag & m_en);
      end else if (slot < NCH) begin
         case (addr[1:0])
            2'd0:    v = m_madr[slot];
            2'd1:    v = m_bcr[slot];
            2'd2:    v = m_chcr[slot];
            default: v = '0;
         endcase
      end
      return v;
   endfunction

   function automatic void model_write(input logic [4:0] addr, input logic [31:0] data);
      int slot;
      slot = int'(addr[4:2]);
      if (addr == 5'd28) begin
         m_dpcr = data;
      end else if (addr == 5'd29) begin
         m_en     = data[16 +: NCH];
         m_master = data[23];
         m_flag   = m_flag & ~data[24 +: NCH];    // write one to clear
      end else if (slot < NCH) begin
         case (addr[1:0])
            2'd0:    m_madr[slot] = data;
            2'd1:    m_bcr[slot]  = data;
            2'd2:    m_chcr[slot] = data;
            default: ;
         endcase
      end
   endfunction

   // requests need the start bit plus the trigger in mode 0
   function automatic logic chan_requests(input int i);
      logic [1:0] mode;
      mode = m_chcr[i][10:9];
      return m_chcr[i][24] && (mode == 2'b01 || (mode == 2'b00 && m_chcr[i][28]));
   endfunction

   function automatic int pick_winner();
      int         w;
      logic [2:0] best;
      w    = -1;
      best = '0;
      for (int i = 0; i < NCH; i++) begin
         if (chan_requests(i) && m_dpcr[4*i+3] && (w < 0 || m_dpcr[4*i +: 3] < best)) begin
            w    = i;
            best = m_dpcr[4*i +: 3];
         end
      end
      return w;
   endfunction

   task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
      @(posedge sys_clk);
      reg_wen_i   <= 1'b1;
      reg_addr_i  <= addr;
      reg_wdata_i <= data;
      @(posedge sys_clk);
      reg_wen_i <= 1'b0;
      model_write(addr, data);
   endtask

   task automatic check_regs();
      for (int a = 0; a < 30; a++) begin
         @(posedge sys_clk);
         reg_addr_i <= 5'(a);
         @(negedge sys_clk);
         compare($sformatf("register %0d", a), model_read(5'(a)), reg_rdata_o);
      end
   endtask

   task automatic run_grant();
      int          w;
      int          cnt;
      logic [31:0] exp;
      w = pick_winner();
      seen_access = 1'b0;
      pdata_q.delete();
      wdata_q.delete();
      @(negedge sys_clk);
      compare("dma_req_o", {31'd0, w >= 0}, {31'd0, dma_req_o});
      @(posedge sys_clk);
      dma_en_i <= 1'b1;
      @(posedge sys_clk);
      dma_en_i <= 1'b0;
      @(negedge sys_clk);
      while (!dma_done_o) @(negedge sys_clk);
      @(negedge sys_clk);                       // strobes and flags have landed
      if (w < 0 || m_bcr[w][15:0] == 16'd0) begin
         if (seen_access) report_failure("bus was used on a grant that moves no word");
         if (w >= 0) begin
            m_chcr[w][24] = 1'b0;
            if (m_master && m_en[w]) m_flag[w] = 1'b1;
         end
      end else begin
         cnt = int'(m_bcr[w][15:0]);
         if (!seen_access) report_failure($sformatf("channel %0d made no bus access", w));
         else compare("first bus address", m_madr[w], first_addr);
         if (m_chcr[w][10:9] == 2'b00) begin
            exp = (cnt == 1) ? 32'h00FF_FFFF : m_madr[w] - 32'd4;
            compare("table entry", exp, mem_model[m_madr[w][11:2]]);
         end else if (!m_chcr[w][0]) begin
            if (pdata_q.size() != 1) report_failure("expected one peripheral read pulse");
            else compare("word to memory", pdata_q[0], mem_model[m_madr[w][11:2]]);
         end else begin
            if (wdata_q.size() != 1) report_failure("expected one peripheral write pulse");
            else compare("word to peripheral", mem_model[m_madr[w][11:2]], wdata_q[0]);
         end
         m_madr[w]      = m_chcr[w][1] ? m_madr[w] - 32'd4 : m_madr[w] + 32'd4;
         m_bcr[w][15:0] = m_bcr[w][15:0] - 16'd1;
      end
      compare("irq_o", {31'd0, |(m_flag & m_en)}, {31'd0, irq_o});
   endtask

   initial begin
      int          cnt;
      logic [31:0] r;
      logic        dec;
      rst          <= 1'b1;
      reg_wen_i    <= 1'b0;
      reg_addr_i   <= '0;
      reg_wdata_i  <= '0;
      dma_en_i     <= 1'b0;
      mem_ack_i    <= 1'b0;
      mem_rdata_i  <= '0;
      chan_rdy_i   <= '0;
      chan_full_i  <= '0;
      chan_rdata_i <= '0;
      ack_wait     <= 0;
      for (int i = 0; i < 1024; i++) mem_model[i] = next_rand() ^ 32'(i);
      for (int i = 0; i < NCH; i++) begin
         m_madr[i] = '0;
         m_bcr[i]  = '0;
         m_chcr[i] = '0;
      end
      m_dpcr   = '0;
      m_en     = '0;
      m_flag   = '0;
      m_master = 1'b0;
      repeat (2) @(posedge sys_clk);
      rst <= 1'b0;

      begin_test("reset");
      @(negedge sys_clk);
      compare("strobes and irq", 32'd0, {13'd0, dma_req_o, dma_done_o, mem_ren_o, mem_wen_o,
                                         chan_ren_o, chan_wen_o, irq_o});
      check_regs();
      end_test();

      begin_test("ordering table clear");
      cnt = 1 + rand_below(8);
      write_reg(5'd28, 32'h0000_0008);
      write_reg(5'd0, 32'h0000_0200);
      write_reg(5'd1, 32'(cnt));
      write_reg(5'd2, 32'h1100_0002);             // start, trigger, step down
      while (m_chcr[0][24]) run_grant();
      check_regs();
      end_test();

      begin_test("block to memory");
      r   = next_rand();
      dec = r[20];
      write_reg(5'd28, 32'h0000_8000);
      write_reg(5'd12, 32'h0000_0600);
      write_reg(5'd13, 32'(1 + rand_below(6)));
      write_reg(5'd14, 32'h0100_0200 | {30'd0, dec, 1'b0});
      while (m_chcr[3][24]) run_grant();
      check_regs();
      end_test();

      begin_test("block from memory");
      r   = next_rand();
      dec = r[20];
      write_reg(5'd28, 32'h0800_0000);
      write_reg(5'd24, 32'h0000_0700);
      write_reg(5'd25, 32'(1 + rand_below(6)));
      write_reg(5'd26, 32'h0100_0201 | {30'd0, dec, 1'b0});
      while (m_chcr[6][24]) run_grant();
      check_regs();
      end_test();

      begin_test("priority");
      for (int i = 0; i < NCH; i++) begin
         write_reg(5'(4 * i), 32'h0000_0820 + 32'(i * 64));
         write_reg(5'(4 * i + 1), 32'(1 + rand_below(3)));
         write_reg(5'(4 * i + 2), 32'h1100_0002);
      end
      write_reg(5'd28, next_rand());
      repeat (12) begin
         run_grant();
         check_regs();
      end
      end_test();

      begin_test("interrupts");
      r = next_rand();
      write_reg(5'd29, {8'd0, 1'b1, r[30:24], 16'd0});
      r = next_rand();
      write_reg(5'd28, (r & 32'h0777_7777) | 32'h0888_8888);
      for (int i = 0; i < NCH; i++) begin
         write_reg(5'(4 * i + 1), 32'd0);
         write_reg(5'(4 * i + 2), 32'h0100_0200);  // mode 1, count 0, only irq
      end
      repeat (8) run_grant();                       // last one finds no requester
      check_regs();
      r = next_rand();
      write_reg(5'd29, {1'b0, r[30:24], m_master, m_en, 16'd0});
      check_regs();
      compare("irq_o after clear", {31'd0, |(m_flag & m_en)}, {31'd0, irq_o});
      end_test();

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* build.f */
src/dma_pkg.sv
src/dma_if.sv
src/dma_reg_bank.sv
src/dma_interrupts.sv
src/dma_channel.sv
src/dma_controller.sv
src/dma_top.sv
tests/tb_dma.sv

/* run.sh */
#!/bin/sh
# build and run the DMA testbench, the verdict comes from the pass line in sim.log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_dma -f build.f -o tb_dma_sim \
   > build.log 2>&1 \
   && ./obj_dir/tb_dma_sim > sim.log 2>&1 \
   || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "^=== PASS ===$" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }
